// File: cpu_tests.mem
// Three records of 24 hex words: words 0-15 memory image for byte addresses 0-30,
// 16-21 expected store address/data pairs, 22 store count, 23 halt PC
// Test 1 byte loads, ADD, SUB, XOR, then stores
A134 // 00 LLB R1, 34
B112 // 02 LHB R1, 12
A20F // 04 LLB R2, 0F
0312 // 06 ADD R3, R1, R2
1431 // 08 SUB R4, R3, R1
2532 // 0A XOR R5, R3, R2
A640 // 0C LLB R6, 40
9360 // 0E SW R3, [R6+0]
9461 // 10 SW R4, [R6+2]
956F // 12 SW R5, [R6-2]
F000 // 14 HLT
0000
0000
0000
0000
0000
0040 // Store 0 address
1243
0042 // Store 1 address
000F
003E // Store 2 address
124C
0003 // Store count
0014 // Halt PC
// Test 2 loads under random read delays, stored back
A118 // 00 LLB R1, 18
8210 // 02 LW R2, [R1+0]
8311 // 04 LW R3, [R1+2]
8412 // 06 LW R4, [R1+4]
0523 // 08 ADD R5, R2, R3
9514 // 0A SW R5, [R1+8]
9413 // 0C SW R4, [R1+6]
8613 // 0E LW R6, [R1+6]
9615 // 10 SW R6, [R1+A]
F000 // 12 HLT
0000
0000
7F00 // 18 data
0155 // 1A data
BEEF // 1C data
5A5A // 1E data, overwritten
0020 // Store 0 address
8055
001E // Store 1 address
BEEF
0022 // Store 2 address
BEEF
0003 // Store count
0012 // Halt PC
// Test 3 taken and not-taken branches
A120 // 00 LLB R1, 20
A220 // 02 LLB R2, 20
1312 // 04 SUB R3, R1, R2
C002 // 06 B NE +2, not taken
9110 // 08 SW R1, [R1+0]
C201 // 0A B EQ +1, taken
9311 // 0C SW R3, [R1+2] skipped
1431 // 0E SUB R4, R3, R1
C601 // 10 B LT +1, taken
9312 // 12 SW R3, [R1+4] skipped
9413 // 14 SW R4, [R1+6]
CE01 // 16 B always +1
9114 // 18 SW R1, [R1+8] skipped
9215 // 1A SW R2, [R1+A]
F000 // 1C HLT
0000
0020 // Store 0 address
0020
0026 // Store 1 address
FFE0
002A // Store 2 address
0020
0003 // Store count
001C // Halt PC

// File: filelist.f
source/cpu_pkg.sv
source/alu.sv
source/pc_unit.sv
source/reg_file.sv
source/mem_port.sv
source/cpu_control.sv
source/cpu_core.sv
test/tb_clock.sv
test/tb_cpu_core.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
rm -rf obj_dir
verilator --binary --timing --top-module tb_cpu_core -f filelist.f -o sim_cpu \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_cpu > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: test/tb_cpu_core.sv
`timescale 1ns/10ps

module tb_cpu_core;
  import cpu_pkg::*;

  localparam int NUM_TESTS    = 3;
  localparam int REC_WORDS    = 24;    // Image, store pairs, count, halt PC
  localparam int IMG_WORDS    = 16;
  localparam int MAX_STORES   = 3;
  localparam int MEM_WORDS    = 32768; // Whole 16-bit byte space
  localparam int RST_LIMIT    = 20;
  localparam int HLT_LIMIT    = 2000;
  localparam int QUIET_CYCLES = 10;

  logic  clk, rst, restart;
  logic  mem_data_valid;
  word_t mem_data_in;
  logic  mem_en, mem_wr, hlt;
  word_t mem_addr, mem_data_out, pc;

  logic [DATA_W-1:0] tests [NUM_TESTS*REC_WORDS];  // Flat copy of cpu_tests.mem
  word_t  mem [MEM_WORDS];
  word_t  store_addr [$];  // Stores in the order the core issued them
  word_t  store_data [$];
  integer seed;
  int     read_wait;       // Cycles left before valid
  logic   read_armed;      // Delay drawn for the open read
  int     test_errors, tests_passed, tests_failed;

  tb_clock i_clk (.restart(restart), .clk(clk), .rst(rst));

  cpu_core i_dut (
    .clk(clk), .rst(rst),
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_data_out(mem_data_out),
    .hlt(hlt), .pc(pc)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    #2;
    if (!mem_en || mem_data_valid) begin
      mem_data_valid = 1'b0;  // Valid lasts one cycle and closes the read
      mem_data_in    = '0;
      read_armed     = 1'b0;
    end else if (mem_wr) begin
      mem[mem_addr[DATA_W-1:1]] = mem_data_out;
      store_addr.push_back(mem_addr);
      store_data.push_back(mem_data_out);
    end else begin
      if (!read_armed) begin
        read_armed = 1'b1;
        read_wait  = $unsigned($random(seed)) % 4;  // 0 to 3 cycles late
      end
      if (read_wait == 0) begin
        mem_data_valid = 1'b1;
        mem_data_in    = mem[mem_addr[DATA_W-1:1]];
      end else begin
        read_wait = read_wait - 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  // Port idle and hlt low with PC at zero
  task automatic check_reset_state();
    check_value("mem_en", 16'd0, word_t'(mem_en));
    check_value("mem_wr", 16'd0, word_t'(mem_wr));
    check_value("hlt", 16'd0, word_t'(hlt));
    check_value("pc", 16'd0, pc);
  endtask

  task automatic run_test(input int t);
    int    base;
    int    i;
    int    cycles;
    int    exp_count;
    word_t halt_pc;
    base        = t * REC_WORDS;
    halt_pc     = tests[base + 23];
    exp_count   = int'(tests[base + 22]);
    test_errors = 0;

    // Fresh image and an empty store log
    for (i = 0; i < MEM_WORDS; i++) mem[i] = '0;
    for (i = 0; i < IMG_WORDS; i++) mem[i] = tests[base + i];
    store_addr.delete();
    store_data.delete();
    if (tests[base + int'(halt_pc[DATA_W-1:1])][OPC_MSB:OPC_LSB] != OP_HLT) begin
      $display("test %0d: record has no HLT at its halt PC", t + 1);
      test_errors++;
    end

    if (t > 0) begin
      restart = 1'b1;  // Seen by tb_clock on the next edge
      @(posedge clk);
      #2;
      restart = 1'b0;
    end
    @(posedge clk);
    #2;
    check_reset_state();  // rst still high

    cycles = 0;
    while (rst && cycles < RST_LIMIT) begin
      @(posedge clk or negedge rst);  // Wakes right after rst falls
      cycles++;
    end
    if (rst) begin
      $display("test %0d: reset was never released", t + 1);
      test_errors++;
    end else begin
      check_reset_state();  // First cycle out of reset
    end

    cycles = 0;
    while (!hlt && cycles < HLT_LIMIT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!hlt) begin
      $display("test %0d: hlt never rose within %0d cycles", t + 1, HLT_LIMIT);
      test_errors++;
    end else begin
      check_value("pc", halt_pc, pc);
      for (i = 0; i < QUIET_CYCLES; i++) begin  // Halted core stays off the bus
        @(posedge clk);
        #2;
        check_value("mem_en", 16'd0, word_t'(mem_en));
        check_value("hlt", 16'd1, word_t'(hlt));
        check_value("pc", halt_pc, pc);
      end
    end

    // Stores in issue order
    check_value("store count", word_t'(exp_count), word_t'(store_addr.size()));
    for (i = 0; i < MAX_STORES; i++) begin
      if (i < exp_count && i < store_addr.size()) begin
        check_value($sformatf("store %0d mem_addr", i), tests[base + 16 + 2*i], store_addr[i]);
        check_value($sformatf("store %0d mem_data_out", i), tests[base + 17 + 2*i],
                    store_data[i]);
      end
    end

    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d passed, %0d stores, halt at %h", t + 1, store_addr.size(), pc);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", t + 1, test_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    restart        = 1'b0;
    mem_data_valid = 1'b0;
    mem_data_in    = '0;
    read_armed     = 1'b0;
    read_wait      = 0;
    seed           = 32'he3bffd45;
    tests_passed   = 0;
    tests_failed   = 0;
    $readmemh("cpu_tests.mem", tests);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  input  logic restart,  // Sampled on the rising edge, starts a new reset
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD = 10;  // 20 ns period
  localparam int RST_CYCLES  = 8;

  int rst_left;  // Edges still to be seen with rst high

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    rst_left = RST_CYCLES;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset moves 2 ns after the edge, like every other input
  always @(posedge clk) begin
    if (restart) rst_left = RST_CYCLES;
    else if (rst_left > 0) rst_left = rst_left - 1;
    #2;
    rst = (rst_left > 0);
  end

endmodule

// File: source/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
  input  logic           clk,             // System clock
  input  logic           rst,             // Synchronous, active high

  // External memory port
  input  logic           mem_data_valid,  // Read data present this cycle
  input  cpu_pkg::word_t mem_data_in,
  output logic           mem_en,
  output cpu_pkg::word_t mem_addr,
  output logic           mem_wr,
  output cpu_pkg::word_t mem_data_out,

  output logic           hlt,             // Stays high once HLT decoded
  output cpu_pkg::word_t pc
);
  import cpu_pkg::*;

  // Control strobes
  logic     fetch_req, load_req, store_req;
  logic     mem_done;
  logic     ex_en;
  alu_op_t  alu_op;
  logic     reg_wr_en, wb_load;
  logic     pc_inc, pc_branch;

  // Datapath
  word_t    ir;              // Instruction held for the whole instruction
  reg_idx_t src1_addr, src2_addr;
  word_t    src1_data, src2_data;
  word_t    alu_result;      // ALU output, also the LW/SW address
  word_t    load_data;
  flags_t   flags;

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////
  cpu_control i_ctrl (
    .clk(clk), .rst(rst), .ir(ir), .mem_done(mem_done),
    .fetch_req(fetch_req), .load_req(load_req), .store_req(store_req),
    .ex_en(ex_en), .alu_op(alu_op),
    .src1_addr(src1_addr), .src2_addr(src2_addr),
    .reg_wr_en(reg_wr_en), .wb_load(wb_load),
    .pc_inc(pc_inc), .pc_branch(pc_branch), .hlt(hlt)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath blocks
  //////////////////////////////////////////////////////////////////////
  pc_unit i_pc (
    .clk(clk), .rst(rst), .pc_inc(pc_inc), .pc_branch(pc_branch),
    .ir(ir), .flags(flags), .pc(pc)
  );

  reg_file i_rf (
    .clk(clk), .rst(rst), .ir(ir),
    .src1_addr(src1_addr), .src2_addr(src2_addr),
    .wr_en(reg_wr_en), .wb_load(wb_load),
    .alu_result(alu_result), .load_data(load_data),
    .src1_data(src1_data), .src2_data(src2_data)
  );

  alu i_alu (
    .clk(clk), .rst(rst), .ex_en(ex_en), .alu_op(alu_op), .ir(ir),
    .src1_data(src1_data), .src2_data(src2_data),
    .alu_result(alu_result), .flags(flags)
  );

  mem_port i_mem (
    .clk(clk), .rst(rst),
    .fetch_req(fetch_req), .load_req(load_req), .store_req(store_req),
    .pc(pc), .alu_result(alu_result), .store_data(src2_data),  // SW data is src2
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in),
    .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_data_out(mem_data_out),
    .ir(ir), .load_data(load_data), .mem_done(mem_done)
  );

endmodule

`default_nettype wire

// File: source/cpu_control.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::word_t    ir,
  input  logic              mem_done,   // Read finished, or store accepted
  output logic              fetch_req,  // One-cycle request strobes
  output logic              load_req,
  output logic              store_req,
  output logic              ex_en,
  output cpu_pkg::alu_op_t  alu_op,
  output cpu_pkg::reg_idx_t src1_addr,
  output cpu_pkg::reg_idx_t src2_addr,
  output logic              reg_wr_en,
  output logic              wb_load,    // Write back load word, not ALU result
  output logic              pc_inc,
  output logic              pc_branch,
  output logic              hlt
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    S_FETCH, S_DECODE, S_EXECUTE, S_MEM, S_WRITEBACK, S_HALT
  } state_t;

  state_t  state, state_nxt;
  logic    req_sent;           // Request of this state already issued
  opcode_t op;
  logic    is_alu, is_mem;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////
  assign op     = opcode_t'(ir[OPC_MSB:OPC_LSB]);
  assign is_alu = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR) ||
                  (op == OP_LLB) || (op == OP_LHB);
  assign is_mem = (op == OP_LW) || (op == OP_SW);
  assign wb_load = (op == OP_LW);

  always_comb begin
    case (op)
      OP_SUB:       alu_op = ALU_SUB;
      OP_XOR:       alu_op = ALU_XOR;
      OP_LLB:       alu_op = ALU_LLB;
      OP_LHB:       alu_op = ALU_LHB;
      OP_LW, OP_SW: alu_op = ALU_ADDR;
      default:      alu_op = ALU_ADD;
    endcase
  end

  // Byte loads modify rd in place, so rd is read as the first operand
  assign src1_addr = (op == OP_LLB || op == OP_LHB) ? ir[RD_MSB -: REG_AW]
                                                     : ir[RS_MSB -: REG_AW];
  // SW names its data register in bits 11:8, same slot as LW's target
  assign src2_addr = (op == OP_SW) ? ir[RD_MSB -: REG_AW] : ir[RT_MSB -: REG_AW];

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////
  assign fetch_req = (state == S_FETCH) && !req_sent;
  assign load_req  = (state == S_MEM) && (op == OP_LW) && !req_sent;
  assign store_req = (state == S_MEM) && (op == OP_SW);
  assign hlt       = (state == S_HALT);

  always_comb begin
    state_nxt = state;
    ex_en     = 1'b0;
    pc_inc    = 1'b0;
    pc_branch = 1'b0;
    reg_wr_en = 1'b0;
    case (state)
      // A store's done lands before req_sent is set, so it is ignored here
      S_FETCH:  if (req_sent && mem_done) state_nxt = S_DECODE;
      S_DECODE: state_nxt = (op == OP_HLT) ? S_HALT : S_EXECUTE;
      S_EXECUTE: begin
        ex_en = is_alu || is_mem;
        if (op == OP_B) begin
          pc_branch = 1'b1;            // Branch ends here
          state_nxt = S_FETCH;
        end else if (is_mem) begin
          state_nxt = S_MEM;
        end else if (is_alu) begin
          state_nxt = S_WRITEBACK;
        end else begin
          pc_inc    = 1'b1;            // Unused opcode, no-op
          state_nxt = S_FETCH;
        end
      end
      S_MEM: begin
        if (op == OP_SW) begin
          pc_inc    = 1'b1;            // Store is fire and forget
          state_nxt = S_FETCH;
        end else if (req_sent && mem_done) begin
          state_nxt = S_WRITEBACK;
        end
      end
      S_WRITEBACK: begin
        reg_wr_en = 1'b1;
        pc_inc    = 1'b1;
        state_nxt = S_FETCH;
      end
      default: state_nxt = S_HALT;    // Parked until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_FETCH;
      req_sent <= 1'b0;
    end else begin
      state    <= state_nxt;
      req_sent <= (state_nxt == state) && (req_sent || fetch_req || load_req);
    end
  end

endmodule

`default_nettype wire

// File: source/mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetch_req,
  input  logic           load_req,
  input  logic           store_req,
  input  cpu_pkg::word_t pc,
  input  cpu_pkg::word_t alu_result,      // Load/store address
  input  cpu_pkg::word_t store_data,
  input  logic           mem_data_valid,
  input  cpu_pkg::word_t mem_data_in,
  output logic           mem_en,
  output logic           mem_wr,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_data_out,
  output cpu_pkg::word_t ir,
  output cpu_pkg::word_t load_data,
  output logic           mem_done         // Cycle after data, or after store request
);
  import cpu_pkg::*;

  logic rd_fetch;  // Open read is an instruction fetch
  logic rd_hit;

  assign rd_hit = mem_en && !mem_wr && mem_data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_en   <= 1'b0;
      mem_wr   <= 1'b0;
      mem_done <= 1'b0;
      rd_fetch <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (fetch_req || load_req) begin    // Open a read, held until valid
        mem_en   <= 1'b1;
        mem_wr   <= 1'b0;
        rd_fetch <= fetch_req;
      end else if (store_req) begin       // Write lasts one cycle
        mem_en   <= 1'b1;
        mem_wr   <= 1'b1;
        mem_done <= 1'b1;
      end else if (mem_en && mem_wr) begin
        mem_en <= 1'b0;
        mem_wr <= 1'b0;
      end else if (rd_hit) begin
        mem_en   <= 1'b0;
        mem_done <= 1'b1;
      end
    end
  end

  // Address, write data and captured words
  always_ff @(posedge clk) begin
    if (fetch_req) mem_addr <= pc;
    else if (load_req || store_req) mem_addr <= alu_result;
    if (store_req) mem_data_out <= store_data;
    if (rd_hit && rd_fetch) ir <= mem_data_in;
    if (rd_hit && !rd_fetch) load_data <= mem_data_in;
  end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::word_t    ir,          // Destination comes from bits 11:8
  input  cpu_pkg::reg_idx_t src1_addr,
  input  cpu_pkg::reg_idx_t src2_addr,
  input  logic              wr_en,
  input  logic              wb_load,
  input  cpu_pkg::word_t    alu_result,
  input  cpu_pkg::word_t    load_data,
  output cpu_pkg::word_t    src1_data,
  output cpu_pkg::word_t    src2_data
);
  import cpu_pkg::*;

  word_t    regs [NUM_REGS];
  reg_idx_t wr_addr;
  word_t    wr_data;

  assign wr_addr = ir[RD_MSB -: REG_AW];
  assign wr_data = wb_load ? load_data : alu_result;  // Writeback source

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // R0 is hardwired to zero
  assign src1_data = (src1_addr == '0) ? '0 : regs[src1_addr];
  assign src2_data = (src2_addr == '0) ? '0 : regs[src2_addr];

endmodule

`default_nettype wire

// File: source/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             pc_inc,     // Step to next instruction
  input  logic             pc_branch,  // Resolve a B instruction
  input  cpu_pkg::word_t   ir,
  input  cpu_pkg::flags_t  flags,
  output cpu_pkg::word_t   pc
);
  import cpu_pkg::*;

  word_t pc_plus2;
  word_t br_offset;  // 2*sext(imm9)
  logic  taken;

  assign pc_plus2  = pc + PC_STEP;
  assign br_offset = {{(DATA_W-IMM9_W-1){ir[IMM9_W-1]}}, ir[IMM9_W-1:0], 1'b0};

  // Condition check on the flags left by the last ALU instruction
  always_comb begin
    taken = 1'b0;
    case (ir[RD_MSB -: COND_W])
      COND_NE:     taken = !flags.z;
      COND_EQ:     taken = flags.z;
      COND_GT:     taken = !flags.z && !flags.n;
      COND_LT:     taken = flags.n;
      COND_GE:     taken = flags.z || !flags.n;
      COND_LE:     taken = flags.z || flags.n;
      COND_OV:     taken = flags.v;
      COND_ALWAYS: taken = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_branch) begin
      pc <= taken ? (pc_plus2 + br_offset) : pc_plus2;  // Relative to PC+2
    end else if (pc_inc) begin
      pc <= pc_plus2;
    end
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  logic              clk,
  input  logic              rst,
  input  logic              ex_en,       // Capture result and flags
  input  cpu_pkg::alu_op_t  alu_op,
  input  cpu_pkg::word_t    ir,          // Immediates
  input  cpu_pkg::word_t    src1_data,
  input  cpu_pkg::word_t    src2_data,
  output cpu_pkg::word_t    alu_result,
  output cpu_pkg::flags_t   flags
);
  import cpu_pkg::*;

  word_t              res_nxt;
  logic               ovf;         // Signed overflow of ADD or SUB
  logic [IMM8_W-1:0]  imm8;
  word_t              mem_offset;  // 2*sext(imm4)

  assign imm8       = ir[IMM8_W-1:0];
  assign mem_offset = {{(DATA_W-IMM4_W-1){ir[IMM4_W-1]}}, ir[IMM4_W-1:0], 1'b0};

  always_comb begin
    res_nxt = '0;
    ovf     = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        res_nxt = src1_data + src2_data;  // Wraps
        ovf     = (src1_data[DATA_W-1] == src2_data[DATA_W-1]) &&
                  (res_nxt[DATA_W-1] != src1_data[DATA_W-1]);
      end
      ALU_SUB: begin
        res_nxt = src1_data - src2_data;
        ovf     = (src1_data[DATA_W-1] != src2_data[DATA_W-1]) &&
                  (res_nxt[DATA_W-1] != src1_data[DATA_W-1]);
      end
      ALU_XOR:  res_nxt = src1_data ^ src2_data;
      ALU_LLB:  res_nxt = {src1_data[DATA_W-1:IMM8_W], imm8};  // Keep high byte
      ALU_LHB:  res_nxt = {imm8, src1_data[IMM8_W-1:0]};       // Keep low byte
      ALU_ADDR: res_nxt = src1_data + mem_offset;
      default:  res_nxt = '0;
    endcase
  end

  // Result register
  always_ff @(posedge clk) begin
    if (ex_en) alu_result <= res_nxt;
  end

  // Flags, only the ones the op defines
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (ex_en) begin
      if (alu_op == ALU_ADD || alu_op == ALU_SUB) begin
        flags <= '{z: (res_nxt == '0), v: ovf, n: res_nxt[DATA_W-1]};
      end else if (alu_op == ALU_XOR) begin
        flags.z <= (res_nxt == '0);  // V and N held
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////////////////////////
  localparam int DATA_W   = 16;  // Data word and byte address width
  localparam int REG_AW   = 4;   // Register index width
  localparam int NUM_REGS = 16;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // Flag register, Z in the top bit
  typedef struct packed {
    logic z;  // Result was zero
    logic v;  // Signed overflow
    logic n;  // Result negative
  } flags_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction word fields
  //////////////////////////////////////////////////////////////////////
  localparam int OPC_MSB = 15;
  localparam int OPC_LSB = 12;
  localparam int RD_MSB  = 11;  // rd, or branch condition in 11:9
  localparam int RS_MSB  = 7;
  localparam int RT_MSB  = 3;
  localparam int IMM4_W  = 4;   // LW/SW offset
  localparam int IMM8_W  = 8;   // LLB/LHB byte
  localparam int IMM9_W  = 9;   // Branch offset
  localparam int COND_W  = 3;

  localparam word_t PC_STEP = 16'd2;  // One instruction is two bytes

  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_HLT = 4'hF
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_LLB, ALU_LHB,
    ALU_ADDR  // rs + 2*sext(imm4), flags untouched
  } alu_op_t;

  // Branch conditions, bits 11:9
  localparam logic [COND_W-1:0] COND_NE     = 3'b000;
  localparam logic [COND_W-1:0] COND_EQ     = 3'b001;
  localparam logic [COND_W-1:0] COND_GT     = 3'b010;
  localparam logic [COND_W-1:0] COND_LT     = 3'b011;
  localparam logic [COND_W-1:0] COND_GE     = 3'b100;
  localparam logic [COND_W-1:0] COND_LE     = 3'b101;
  localparam logic [COND_W-1:0] COND_OV     = 3'b110;
  localparam logic [COND_W-1:0] COND_ALWAYS = 3'b111;

endpackage
